// ==== Bender.yml ====
package:
  name: issue_cluster

sources:
  - files:
      - hw/iq_pkg.sv
      - hw/issue_queue.sv
      - hw/dispatch_stage.sv
      - hw/exec_pipe.sv
      - hw/issue_cluster.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_issue_cluster.sv

// ==== compile.f ====
hw/iq_pkg.sv
hw/issue_queue.sv
hw/dispatch_stage.sv
hw/exec_pipe.sv
hw/issue_cluster.sv
verification/tb_clk_gen.sv
verification/tb_issue_cluster.sv

// ==== hw/dispatch_stage.sv ====
`timescale 1ns/1ns

module dispatch_stage (
    input  logic clk,
    input  logic rst_n,
    input  iq_pkg::dispatch_req_t dispatch,
    output logic dispatch_ready,
    input  logic alu_full,
    input  logic mul_full,
    input  iq_pkg::wake_t [iq_pkg::WAKE_NUM-1:0] wake,
    output logic alu_write_valid,
    output logic mul_write_valid,
    output iq_pkg::iq_entry_t write_entry
);
    import iq_pkg::*;

    localparam int TAG_NUM = 2 ** TAG_W;

    logic [TAG_NUM-1:0] ready_q;
    word_t prf [TAG_NUM];
    entry_type_t req_type;
    logic accept;
    operand_t src1_lookup;
    operand_t src2_lookup;
    iq_entry_t entry_d;

    // tag 0 reads as a ready zero
    function automatic operand_t lookup(tag_t tag);
        operand_t opnd;
        opnd.valid = ready_q[tag];
        opnd.tag = tag;
        opnd.data = (tag == '0) ? '0 : prf[tag];
        return opnd;
    endfunction

    assign req_type = type_of(dispatch.op);
    assign dispatch_ready = (req_type == mul_type) ? !mul_full : !alu_full;
    assign accept = dispatch.valid && dispatch_ready;

    always_comb begin
        src1_lookup = lookup(dispatch.src1);
        if (dispatch.use_imm) begin
            src2_lookup.valid = 1'b1;
            src2_lookup.tag = '0;
            src2_lookup.data = dispatch.src2.imm;
        end else begin
            src2_lookup = lookup(dispatch.src2.phys.tag);
        end

        // catch wakes that land in the lookup cycle
        entry_d.op = dispatch.op;
        entry_d.dst = dispatch.dst;
        entry_d.src1 = apply_wake(src1_lookup, wake);
        entry_d.src2 = apply_wake(src2_lookup, wake);
    end

    // scoreboard
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= TAG_NUM'(1);
        end else begin
            for (int i = 0; i < WAKE_NUM; i++) begin
                if (wake[i].valid && wake[i].tag != '0) begin
                    ready_q[wake[i].tag] <= 1'b1;
                end
            end
            // new producer overrides an old wake
            if (accept && dispatch.dst != '0) begin
                ready_q[dispatch.dst] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < WAKE_NUM; i++) begin
            if (wake[i].valid) begin
                prf[wake[i].tag] <= wake[i].data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_write_valid <= 1'b0;
            mul_write_valid <= 1'b0;
        end else begin
            alu_write_valid <= accept && (req_type == alu_type);
            mul_write_valid <= accept && (req_type == mul_type);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            write_entry <= entry_d;
        end
    end

    // a request that is not taken stays on the port
    assert property (@(posedge clk) disable iff (!rst_n)
        (dispatch.valid && !dispatch_ready) |=> (dispatch.valid && $stable(dispatch)))
        else $error("dispatch request changed while stalled");

endmodule

// ==== hw/exec_pipe.sv ====
`timescale 1ns/1ns

module exec_pipe #(
    parameter int LATENCY = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic issue_valid,
    input  iq_pkg::iq_entry_t issue_entry,
    output iq_pkg::wake_t wake
);
    import iq_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t result;

    logic [LATENCY-1:0] valid_q;
    tag_t [LATENCY-1:0] tag_q;
    word_t [LATENCY-1:0] data_q;

    assign src_a = issue_entry.src1.data;
    assign src_b = issue_entry.src2.data;

    always_comb begin
        case (issue_entry.op)
            op_add: result = src_a + src_b;
            op_sub: result = src_a - src_b;
            op_xor: result = src_a ^ src_b;
            default: result = src_a * src_b;
        endcase
    end

    // result computed up front, then carried down the stages
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= issue_valid;
            for (int s = 1; s < LATENCY; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= issue_entry.dst;
        data_q[0] <= result;
        for (int s = 1; s < LATENCY; s++) begin
            tag_q[s] <= tag_q[s-1];
            data_q[s] <= data_q[s-1];
        end
    end

    assign wake = '{
        valid: valid_q[LATENCY-1],
        tag: tag_q[LATENCY-1],
        data: data_q[LATENCY-1]
    };

endmodule

// ==== hw/iq_pkg.sv ====
package iq_pkg;

    // physical tags
    localparam int TAG_W = 5;
    localparam int WAKE_NUM = 2;

    // default queue depths, by queue type
    localparam int ALU_IQ_LEN = 8;
    localparam int MUL_IQ_LEN = 4;

    typedef logic [31:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_xor = 2'd2,
        op_mul = 2'd3
    } op_t;

    typedef enum logic {
        alu_type = 1'b0,
        mul_type = 1'b1
    } entry_type_t;

    // second source, immediate or tag
    typedef union packed {
        word_t imm;
        struct packed {
            logic [31-TAG_W:0] pad;
            tag_t tag;
        } phys;
    } src2_u;

    typedef struct packed {
        logic valid;
        op_t op;
        tag_t dst;
        tag_t src1;
        logic use_imm;
        src2_u src2;
    } dispatch_req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
        word_t data;
    } operand_t;

    typedef struct packed {
        op_t op;
        tag_t dst;
        operand_t src1;
        operand_t src2;
    } iq_entry_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
        word_t data;
    } wake_t;

    function automatic entry_type_t type_of(op_t op);
        return (op == op_mul) ? mul_type : alu_type;
    endfunction

    // each waiting source takes its own broadcast data
    function automatic operand_t apply_wake(operand_t opnd, wake_t [WAKE_NUM-1:0] wake);
        operand_t result;
        result = opnd;
        for (int i = 0; i < WAKE_NUM; i++) begin
            if (!opnd.valid && wake[i].valid && wake[i].tag == opnd.tag) begin
                result.valid = 1'b1;
                result.data = wake[i].data;
            end
        end
        return result;
    endfunction

    function automatic iq_entry_t wake_entry(iq_entry_t entry, wake_t [WAKE_NUM-1:0] wake);
        iq_entry_t result;
        result = entry;
        result.src1 = apply_wake(entry.src1, wake);
        result.src2 = apply_wake(entry.src2, wake);
        return result;
    endfunction

endpackage

// ==== hw/issue_cluster.sv ====
`timescale 1ns/1ns

module issue_cluster #(
    parameter int ALU_QUEUE_LEN = iq_pkg::ALU_IQ_LEN,
    parameter int MUL_QUEUE_LEN = iq_pkg::MUL_IQ_LEN,
    parameter int ALU_LATENCY = 1,
    parameter int MUL_LATENCY = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  iq_pkg::dispatch_req_t dispatch,
    output logic dispatch_ready,
    output iq_pkg::wake_t [iq_pkg::WAKE_NUM-1:0] completion
);
    import iq_pkg::*;

    logic alu_full;
    logic mul_full;
    logic alu_write_valid;
    logic mul_write_valid;
    iq_entry_t write_entry;

    logic alu_issue_valid;
    logic mul_issue_valid;
    iq_entry_t alu_issue_entry;
    iq_entry_t mul_issue_entry;

    wake_t alu_wake;
    wake_t mul_wake;
    wake_t [WAKE_NUM-1:0] wake;

    // wake 0 from the alu pipe, wake 1 from the multiplier
    assign wake = {mul_wake, alu_wake};
    assign completion = wake;

    dispatch_stage u_dispatch (
        .clk             (clk),
        .rst_n           (rst_n),
        .dispatch        (dispatch),
        .dispatch_ready  (dispatch_ready),
        .alu_full        (alu_full),
        .mul_full        (mul_full),
        .wake            (wake),
        .alu_write_valid (alu_write_valid),
        .mul_write_valid (mul_write_valid),
        .write_entry     (write_entry)
    );

    issue_queue #(
        .ENTRY_TYPE (alu_type),
        .QUEUE_LEN  (ALU_QUEUE_LEN),
        .READ_NUM   (1)
    ) u_alu_iq (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .write_valid (alu_write_valid),
        .write_entry (write_entry),
        .wake        (wake),
        .issue_valid (alu_issue_valid),
        .issue_entry (alu_issue_entry),
        .full        (alu_full)
    );

    issue_queue #(
        .ENTRY_TYPE (mul_type),
        .QUEUE_LEN  (MUL_QUEUE_LEN),
        .READ_NUM   (1)
    ) u_mul_iq (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .write_valid (mul_write_valid),
        .write_entry (write_entry),
        .wake        (wake),
        .issue_valid (mul_issue_valid),
        .issue_entry (mul_issue_entry),
        .full        (mul_full)
    );

    exec_pipe #(
        .LATENCY (ALU_LATENCY)
    ) u_alu_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue_valid (alu_issue_valid),
        .issue_entry (alu_issue_entry),
        .wake        (alu_wake)
    );

    exec_pipe #(
        .LATENCY (MUL_LATENCY)
    ) u_mul_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue_valid (mul_issue_valid),
        .issue_entry (mul_issue_entry),
        .wake        (mul_wake)
    );

endmodule

// ==== hw/issue_queue.sv ====
`timescale 1ns/1ns

module issue_queue #(
    parameter iq_pkg::entry_type_t ENTRY_TYPE = iq_pkg::alu_type,
    parameter int QUEUE_LEN = (ENTRY_TYPE == iq_pkg::mul_type) ? iq_pkg::MUL_IQ_LEN
                                                               : iq_pkg::ALU_IQ_LEN,
    parameter int READ_NUM = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic write_valid,
    input  iq_pkg::iq_entry_t write_entry,
    input  iq_pkg::wake_t [iq_pkg::WAKE_NUM-1:0] wake,
    output logic [READ_NUM-1:0] issue_valid,
    output iq_pkg::iq_entry_t [READ_NUM-1:0] issue_entry,
    output logic full
);
    import iq_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_LEN);
    typedef logic [PTR_W-1:0] ptr_t;

    // slot 0 is the oldest
    iq_entry_t [QUEUE_LEN-1:0] slots;
    iq_entry_t [QUEUE_LEN-1:0] slots_woken;
    iq_entry_t [QUEUE_LEN-1:0] slots_next;
    iq_entry_t write_woken;
    logic [QUEUE_LEN-1:0] picked;
    ptr_t tail;
    int count_next;

    always_comb begin
        for (int j = 0; j < QUEUE_LEN; j++) begin
            slots_woken[j] = wake_entry(slots[j], wake);
        end
        write_woken = wake_entry(write_entry, wake);
    end

    always_comb begin
        int n_read;
        int k;

        issue_valid = '0;
        issue_entry = '0;
        picked = '0;
        n_read = 0;

        // oldest ready slots first
        for (int i = 0; i < QUEUE_LEN; i++) begin
            if (i < int'(tail) && n_read < READ_NUM &&
                slots_woken[i].src1.valid && slots_woken[i].src2.valid) begin
                picked[i] = 1'b1;
                issue_valid[n_read] = 1'b1;
                issue_entry[n_read] = slots_woken[i];
                n_read = n_read + 1;
            end
        end

        // collapse the survivors towards slot 0
        slots_next = slots_woken;
        k = 0;
        for (int i = 0; i < QUEUE_LEN; i++) begin
            if (i < int'(tail) && !picked[i]) begin
                slots_next[k] = slots_woken[i];
                k = k + 1;
            end
        end

        // incoming write goes straight out if a read port is left
        if (write_valid) begin
            if (n_read < READ_NUM && write_woken.src1.valid && write_woken.src2.valid) begin
                issue_valid[n_read] = 1'b1;
                issue_entry[n_read] = write_woken;
            end else begin
                slots_next[k] = write_woken;
                k = k + 1;
            end
        end

        count_next = k;
    end

    // last slot stays unused
    assign full = (count_next == QUEUE_LEN - 1);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            tail <= '0;
        end else begin
            tail <= ptr_t'(count_next);
        end
    end

    always_ff @(posedge clk) begin
        slots <= slots_next;
    end

    // dispatch sees full and holds back the next write
    assert property (@(posedge clk) disable iff (!rst_n || flush)
        full |=> !write_valid)
        else $error("issue queue type %0d written while full", ENTRY_TYPE);

    assert property (@(posedge clk) disable iff (!rst_n)
        count_next <= QUEUE_LEN - 1)
        else $error("issue queue type %0d tail overflow", ENTRY_TYPE);

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== verification/tb_issue_cluster.sv ====
`timescale 1ns/1ns

module tb_issue_cluster;
    import iq_pkg::*;

    localparam int TOTAL_INSTR = 60 + 40 + 32 + 10 + 20;
    localparam int LIMIT_NS = (TOTAL_INSTR * 40 + 200) * 8;

    logic clk;
    logic rst_n;
    logic flush;
    dispatch_req_t dispatch;
    logic dispatch_ready;
    wake_t [WAKE_NUM-1:0] completion;

    word_t exp_val [32];
    bit known [32];
    bit pending [32];
    tag_t src1_of [32];
    tag_t src2_of [32];
    bit src2_is_tag [32];
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int dispatched = 0;
    int flushed = 0;
    int done_count = 0;
    int stall_count = 0;
    bit watch_alu_side = 0;

    tb_clk_gen #(.PERIOD(8), .RESET_CYCLES(2)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    issue_cluster #(
        .ALU_QUEUE_LEN (8),
        .MUL_QUEUE_LEN (4),
        .ALU_LATENCY   (1),
        .MUL_LATENCY   (3)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .completion     (completion)
    );

    task automatic check_eq(string msg, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    function automatic word_t compute(op_t op, word_t a, word_t b);
        case (op)
            op_add: return a + b;
            op_sub: return a - b;
            op_xor: return a ^ b;
            default: return a * b;
        endcase
    endfunction

    // a tag in flight or still read by something in flight
    function automatic bit busy(int t);
        if (pending[t]) return 1;
        for (int p = 1; p < 32; p++) begin
            if (pending[p] && (src1_of[p] == t || (src2_is_tag[p] && src2_of[p] == t)))
                return 1;
        end
        return 0;
    endfunction

    function automatic tag_t pick_dst(tag_t a, tag_t b);
        int t;
        for (int n = 0; n < 40; n++) begin
            t = $urandom_range(1, 31);
            if (!busy(t) && t != a && t != b) return tag_t'(t);
        end
        for (t = 1; t < 32; t++) begin
            if (!busy(t) && t != a && t != b) return tag_t'(t);
        end
        return '0;
    endfunction

    function automatic tag_t pick_source(bit allow_pending);
        int t;
        for (int n = 0; n < 40; n++) begin
            t = $urandom_range(0, 31);
            if (known[t] && (allow_pending || !pending[t])) return tag_t'(t);
        end
        return '0;
    endfunction

    task automatic monitor();
        tag_t t;
        for (int i = 0; i < WAKE_NUM; i++) begin
            if (completion[i].valid) begin
                t = completion[i].tag;
                if (!pending[t]) begin
                    $display("at %0t ns tag %0d completed with no instruction in flight", $time, t);
                    errors++;
                end else begin
                    check_eq($sformatf("completion data of tag %0d", t),
                        completion[i].data, exp_val[t]);
                    if (pending[src1_of[t]] || (src2_is_tag[t] && pending[src2_of[t]])) begin
                        $display("at %0t ns tag %0d completed before its producer", $time, t);
                        errors++;
                    end
                    pending[t] = 0;
                    done_count++;
                end
            end
        end
    endtask

    task automatic tick();
        @(negedge clk);
        monitor();
    endtask

    // swap in an alu op without valid, look at ready, then put the held request back
    task automatic probe_alu_ready();
        dispatch_req_t held;
        held = dispatch;
        dispatch.valid = 1'b0;
        dispatch.op = op_add;
        #1;
        check_eq("dispatch_ready for an alu op during a multiply stall", dispatch_ready, 1);
        dispatch = held;
    endtask

    task automatic do_dispatch(op_t op, tag_t s1, bit use_imm, tag_t s2, word_t imm,
                               output tag_t dst);
        word_t b;
        dst = pick_dst(s1, use_imm ? tag_t'(0) : s2);
        while (dst == '0) begin
            tick();
            dst = pick_dst(s1, use_imm ? tag_t'(0) : s2);
        end
        dispatch = '0;
        dispatch.valid = 1'b1;
        dispatch.op = op;
        dispatch.dst = dst;
        dispatch.src1 = s1;
        dispatch.use_imm = use_imm;
        if (use_imm)
            dispatch.src2.imm = imm;
        else
            dispatch.src2.phys.tag = s2;
        #1;
        while (!dispatch_ready) begin
            stall_count++;
            if (watch_alu_side)
                probe_alu_ready();
            tick();
            #1;
        end
        // taken on the coming rising edge
        b = use_imm ? imm : exp_val[s2];
        exp_val[dst] = compute(op, exp_val[s1], b);
        known[dst] = 1;
        pending[dst] = 1;
        src1_of[dst] = s1;
        src2_of[dst] = s2;
        src2_is_tag[dst] = !use_imm;
        dispatched++;
        tick();
        dispatch.valid = 1'b0;
    endtask

    task automatic drain();
        bit any;
        any = 1;
        while (any) begin
            any = 0;
            for (int t = 0; t < 32; t++) any |= pending[t];
            if (any) tick();
        end
    endtask

    task automatic report(string name, int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        #(LIMIT_NS);
        $display("timeout: run did not finish within %0d ns", LIMIT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int e;
        bit imm_sel;
        op_t op;
        tag_t s1;
        tag_t s2;
        tag_t d;
        tag_t prev;

        dispatch = '0;
        flush = 1'b0;
        void'($urandom(80));
        for (int t = 0; t < 32; t++) begin
            exp_val[t] = '0;
            known[t] = (t == 0);
            pending[t] = 0;
            src1_of[t] = '0;
            src2_of[t] = '0;
            src2_is_tag[t] = 0;
        end
        @(posedge rst_n);
        tick();
        check_eq("dispatch_ready after reset", dispatch_ready, 1);
        check_eq("completion valid after reset", {completion[1].valid, completion[0].valid}, 0);

        // independent ops
        e = errors;
        for (int n = 0; n < 60; n++) begin
            op = op_t'($urandom_range(0, 3));
            imm_sel = ($urandom_range(0, 9) < 6);
            do_dispatch(op, pick_source(0), imm_sel, pick_source(0), $urandom(), d);
        end
        drain();
        report("test 1 independent ops", e);

        // dependency chains
        e = errors;
        prev = '0;
        for (int n = 0; n < 40; n++) begin
            op = op_t'($urandom_range(0, 3));
            s1 = ($urandom_range(0, 2) != 0) ? prev : pick_source(1);
            imm_sel = $urandom_range(0, 1);
            s2 = pick_source(1);
            do_dispatch(op, s1, imm_sel, s2, $urandom(), d);
            prev = d;
        end
        drain();
        report("test 2 dependency chains", e);

        // consumer dispatched around the producer's wake
        e = errors;
        for (int gap = 0; gap < 4; gap++) begin
            for (int k = 0; k < 4; k++) begin
                op = (k < 2) ? op_add : op_mul;
                do_dispatch(op, pick_source(0), 1, '0, $urandom_range(1, 99), prev);
                repeat (gap) tick();
                op = k[0] ? op_mul : op_sub;
                do_dispatch(op, prev, 1, '0, $urandom_range(1, 99), d);
            end
        end
        drain();
        report("test 3 same-cycle bypass", e);

        // multiply chain fills its queue
        e = errors;
        stall_count = 0;
        watch_alu_side = 1;
        prev = pick_source(0);
        for (int n = 0; n < 10; n++) begin
            do_dispatch(op_mul, prev, 1, '0, 32'd3, d);
            prev = d;
        end
        watch_alu_side = 0;
        if (stall_count == 0) begin
            $display("multiply queue never pushed back on dispatch");
            errors++;
        end
        drain();
        report("test 4 back-pressure", e);

        // flush with work in flight
        e = errors;
        prev = pick_source(0);
        for (int n = 0; n < 6; n++) begin
            do_dispatch((n % 2) ? op_add : op_mul, prev, 1, '0, $urandom(), d);
            prev = d;
        end
        flush = 1'b1;
        d = '0;
        for (int t = 1; t < 32; t++) begin
            if (pending[t]) begin
                pending[t] = 0;
                known[t] = 0;
                flushed++;
                d = 1;
            end
        end
        if (d == '0) begin
            $display("nothing was in flight when the flush was applied");
            errors++;
        end
        tick();
        flush = 1'b0;
        check_eq("dispatch_ready after flush", dispatch_ready, 1);
        repeat (6) tick();
        for (int n = 0; n < 14; n++) begin
            op = op_t'($urandom_range(0, 3));
            do_dispatch(op, pick_source(0), $urandom_range(0, 1), pick_source(0),
                $urandom(), d);
        end
        drain();
        report("test 5 flush", e);

        check_eq("completion count", done_count, dispatched - flushed);
        $display("tests passed %0d, failed %0d, errors %0d, completions %0d",
            tests_passed, tests_failed, errors, done_count);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
